// ==== hw/busArbiter.sv ====
`timescale 1ns/1ps

module busArbiter (
    input  logic                clk,
    input  logic                reset,
    input  rvCorePkg::memReq_t  fetchReq,
    input  rvCorePkg::memReq_t  dataReq,
    output rvCorePkg::memResp_t fetchResp,
    output rvCorePkg::memResp_t dataResp,
    output rvCorePkg::apbReq_t  apbReq,
    input  rvCorePkg::apbResp_t apbResp
);

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apbPhase_e;

    apbPhase_e phase;
    logic grantData;  // 1 = data side owns the bus
    logic xferDone;
    rvCorePkg::memReq_t granted;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= APB_IDLE;
            grantData <= 1'b0;
        end else begin
            case (phase)
                APB_IDLE: begin
                    if (dataReq.valid) begin  // data first
                        grantData <= 1'b1;
                        phase     <= APB_SETUP;
                    end else if (fetchReq.valid) begin
                        grantData <= 1'b0;
                        phase     <= APB_SETUP;
                    end
                end
                APB_SETUP: phase <= APB_ACCESS;
                default:   if (apbResp.pready) phase <= APB_IDLE;  // psel drops a cycle
            endcase
        end
    end

    assign granted  = grantData ? dataReq : fetchReq;
    assign xferDone = (phase == APB_ACCESS) & apbResp.pready;

    assign apbReq = '{paddr: granted.addr,
                      psel: phase != APB_IDLE,
                      penable: phase == APB_ACCESS,
                      pwrite: granted.write,
                      pwdata: granted.wdata,
                      pstrb: granted.write ? granted.strb : '0};

    assign fetchResp = '{done: xferDone & ~grantData, rdata: apbResp.prdata};
    assign dataResp  = '{done: xferDone & grantData, rdata: apbResp.prdata};

endmodule

// ==== hw/coreSequencer.sv ====
`timescale 1ns/1ps

module coreSequencer (
    input  logic clk,
    input  logic reset,
    input  logic isMem,
    input  logic fetchDone,
    input  logic memDone,
    output logic fetchStart,
    output logic latchExec,
    output logic memStart,
    output logic regWriteEn,
    output logic pcUpdate
);

    rvCorePkg::stage_e stage, stageNext;
    logic booted;  // low in the first cycle out of reset

    always_comb begin
        stageNext = stage;
        case (stage)
            rvCorePkg::STAGE_FETCH: if (fetchDone) stageNext = rvCorePkg::STAGE_EXEC;
            rvCorePkg::STAGE_EXEC:  stageNext = isMem ? rvCorePkg::STAGE_MEM : rvCorePkg::STAGE_WB;
            rvCorePkg::STAGE_MEM:   if (memDone) stageNext = rvCorePkg::STAGE_WB;
            default:                stageNext = rvCorePkg::STAGE_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage  <= rvCorePkg::STAGE_FETCH;
            booted <= 1'b0;
        end else begin
            stage  <= stageNext;
            booted <= 1'b1;
        end
    end

    // next fetch is issued alongside the pc update
    assign fetchStart = ~booted | (stage == rvCorePkg::STAGE_WB);
    assign latchExec  = (stage == rvCorePkg::STAGE_EXEC);
    assign memStart   = (stage == rvCorePkg::STAGE_EXEC) & isMem;
    assign regWriteEn = (stage == rvCorePkg::STAGE_WB);
    assign pcUpdate   = (stage == rvCorePkg::STAGE_WB);

endmodule

// ==== hw/decoder.sv ====
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module decoder (
    input  rvCorePkg::word_t instr,
    output rvCorePkg::ctrl_t ctrl,
    output logic             isMem
);

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    rvCorePkg::word_t immI, immS, immB, immU;
    logic [2:0] funct3;

    function automatic rvCorePkg::aluOp_e aluSelect(input logic [2:0] f3, input logic subtract);
        case (f3)
            3'b000:  aluSelect = subtract ? rvCorePkg::ALU_SUB : rvCorePkg::ALU_ADD;
            3'b010:  aluSelect = rvCorePkg::ALU_SLT;
            3'b100:  aluSelect = rvCorePkg::ALU_XOR;
            3'b110:  aluSelect = rvCorePkg::ALU_OR;
            3'b111:  aluSelect = rvCorePkg::ALU_AND;
            default: aluSelect = rvCorePkg::ALU_ADD;
        endcase
    endfunction

    assign funct3 = instr[14:12];
    assign immI = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign immS = {{(`CORE_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{(`CORE_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        ctrl             = '0;  // unknown opcodes fall out as a no-op
        ctrl.aluOp       = rvCorePkg::ALU_ADD;
        ctrl.rd          = instr[11:7];
        ctrl.rs1         = instr[19:15];
        ctrl.rs2         = instr[24:20];
        ctrl.memSize     = funct3[1:0];
        ctrl.memUnsigned = funct3[2];
        ctrl.branchCond  = {funct3[2], funct3[0]};
        case (instr[6:0])
            OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = rvCorePkg::ALU_PASSB;
                ctrl.imm      = immU;
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = aluSelect(funct3, 1'b0);
                ctrl.imm      = immI;
            end
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluSelect(funct3, instr[30]);
            end
            OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.imm      = immI;
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.imm      = immS;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = rvCorePkg::ALU_SUB;  // zero flag for beq/bne
                ctrl.imm    = immB;
            end
            default: ;
        endcase
    end

    assign isMem = ctrl.memRead | ctrl.memWrite;

endmodule

// ==== hw/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
    input  logic             clk,
    input  logic             reset,
    input  logic             latchExec,
    input  rvCorePkg::ctrl_t ctrl,
    input  rvCorePkg::word_t pc,
    input  rvCorePkg::word_t rdata1,
    input  rvCorePkg::word_t rdata2,
    output rvCorePkg::word_t result,
    output rvCorePkg::word_t storeData,
    output logic             branchTaken,
    output rvCorePkg::word_t branchTarget
);

    rvCorePkg::word_t opB, aluOut;
    logic isZero, isLess, condMet;

    assign opB    = ctrl.useImm ? ctrl.imm : rdata2;
    assign isLess = $signed(rdata1) < $signed(opB);
    assign isZero = (aluOut == '0);

    always_comb begin
        case (ctrl.aluOp)
            rvCorePkg::ALU_SUB:   aluOut = rdata1 - opB;
            rvCorePkg::ALU_AND:   aluOut = rdata1 & opB;
            rvCorePkg::ALU_OR:    aluOut = rdata1 | opB;
            rvCorePkg::ALU_XOR:   aluOut = rdata1 ^ opB;
            rvCorePkg::ALU_SLT:   aluOut = rvCorePkg::word_t'(isLess);
            rvCorePkg::ALU_PASSB: aluOut = opB;  // lui
            default:              aluOut = rdata1 + opB;
        endcase
    end

    // beq, bne, blt, bge
    always_comb begin
        case (ctrl.branchCond)
            2'b00:   condMet = isZero;
            2'b01:   condMet = ~isZero;
            2'b10:   condMet = isLess;
            default: condMet = ~isLess;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) branchTaken <= 1'b0;
        else if (latchExec) branchTaken <= ctrl.branch & condMet;
    end

    always_ff @(posedge clk) begin
        if (latchExec) begin
            result       <= aluOut;
            storeData    <= rdata2;
            branchTarget <= pc + ctrl.imm;
        end
    end

endmodule

// ==== hw/fetchUnit.sv ====
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module fetchUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                fetchStart,
    input  logic                pcUpdate,
    input  logic                branchTaken,
    input  rvCorePkg::word_t    branchTarget,
    output rvCorePkg::memReq_t  fetchReq,
    input  rvCorePkg::memResp_t fetchResp,
    output logic                fetchDone,
    output rvCorePkg::word_t    pc,
    output rvCorePkg::word_t    instr
);

    logic reqValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `CORE_RESET_PC;
            reqValid <= 1'b0;
        end else begin
            if (pcUpdate) pc <= branchTaken ? branchTarget : pc + `CORE_XLEN'(4);
            if (fetchStart) reqValid <= 1'b1;
            else if (fetchResp.done) reqValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchResp.done) instr <= fetchResp.rdata;  // instruction register
    end

    assign fetchReq  = '{valid: reqValid, write: 1'b0, addr: pc, wdata: '0, strb: '0};
    assign fetchDone = fetchResp.done & reqValid;

endmodule

// ==== hw/loadStoreUnit.sv ====
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module loadStoreUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                memStart,
    input  rvCorePkg::ctrl_t    ctrl,
    input  rvCorePkg::word_t    addr,
    input  rvCorePkg::word_t    storeData,
    output rvCorePkg::memReq_t  dataReq,
    input  rvCorePkg::memResp_t dataResp,
    output logic                memDone,
    output rvCorePkg::word_t    wbData
);

    logic reqValid;
    logic [1:0] byteOff;
    rvCorePkg::strb_t sizeMask;
    rvCorePkg::word_t laneData, extended, loadData;

    assign byteOff = addr[1:0];

    always_comb begin
        case (ctrl.memSize)
            2'b00:   sizeMask = rvCorePkg::strb_t'(1);
            2'b01:   sizeMask = rvCorePkg::strb_t'(3);
            default: sizeMask = '1;
        endcase
    end

    // ------------------------------------------------------------
    // request build, word aligned address plus lane strobes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) reqValid <= 1'b0;
        else if (memStart) reqValid <= 1'b1;
        else if (dataResp.done) reqValid <= 1'b0;
    end

    assign dataReq = '{valid: reqValid, write: ctrl.memWrite,
                       addr: {addr[`CORE_XLEN-1:2], 2'b00},
                       wdata: storeData << {byteOff, 3'b000},
                       strb: sizeMask << byteOff};
    assign memDone = dataResp.done & reqValid;

    // load lane extraction
    assign laneData = dataResp.rdata >> {byteOff, 3'b000};

    always_comb begin
        case (ctrl.memSize)
            2'b00:   extended = {{(`CORE_XLEN-8){laneData[7] & ~ctrl.memUnsigned}}, laneData[7:0]};
            2'b01:   extended = {{(`CORE_XLEN-16){laneData[15] & ~ctrl.memUnsigned}},
                                 laneData[15:0]};
            default: extended = laneData;
        endcase
    end

    always_ff @(posedge clk) begin
        if (dataResp.done) loadData <= extended;
    end

    assign wbData = ctrl.memRead ? loadData : addr;  // alu result otherwise

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module regFile (
    input  logic               clk,
    input  logic               reset,
    input  rvCorePkg::regIdx_t rs1,
    input  rvCorePkg::regIdx_t rs2,
    output rvCorePkg::word_t   rdata1,
    output rvCorePkg::word_t   rdata2,
    input  logic               writeEn,
    input  rvCorePkg::regIdx_t rd,
    input  rvCorePkg::word_t   wdata
);

    rvCorePkg::word_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) regs[i] <= '0;
        end else if (writeEn && rd != '0) begin  // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// ==== hw/rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
    input  logic               clk,
    input  logic               reset,
    output rvCorePkg::apbReq_t apbReq,
    input  rvCorePkg::apbResp_t apbResp
);

    logic fetchStart, latchExec, memStart, regWriteEn, pcUpdate;
    logic fetchDone, memDone, isMem, branchTaken;
    rvCorePkg::ctrl_t ctrl;
    rvCorePkg::word_t pc, instr, rdata1, rdata2;
    rvCorePkg::word_t result, storeData, branchTarget, wbData;
    rvCorePkg::memReq_t fetchReq, dataReq;
    rvCorePkg::memResp_t fetchResp, dataResp;

    coreSequencer uSequencer (
        .clk(clk), .reset(reset), .isMem(isMem), .fetchDone(fetchDone), .memDone(memDone),
        .fetchStart(fetchStart), .latchExec(latchExec), .memStart(memStart),
        .regWriteEn(regWriteEn), .pcUpdate(pcUpdate)
    );

    fetchUnit uFetch (
        .clk(clk), .reset(reset), .fetchStart(fetchStart), .pcUpdate(pcUpdate),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .fetchReq(fetchReq), .fetchResp(fetchResp), .fetchDone(fetchDone),
        .pc(pc), .instr(instr)
    );

    decoder uDecoder (.instr(instr), .ctrl(ctrl), .isMem(isMem));

    regFile uRegs (
        .clk(clk), .reset(reset), .rs1(ctrl.rs1), .rs2(ctrl.rs2),
        .rdata1(rdata1), .rdata2(rdata2),
        .writeEn(regWriteEn & ctrl.regWrite), .rd(ctrl.rd), .wdata(wbData)
    );

    execUnit uExec (
        .clk(clk), .reset(reset), .latchExec(latchExec), .ctrl(ctrl), .pc(pc),
        .rdata1(rdata1), .rdata2(rdata2), .result(result), .storeData(storeData),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    loadStoreUnit uLsu (
        .clk(clk), .reset(reset), .memStart(memStart), .ctrl(ctrl), .addr(result),
        .storeData(storeData), .dataReq(dataReq), .dataResp(dataResp),
        .memDone(memDone), .wbData(wbData)
    );

    busArbiter uArbiter (
        .clk(clk), .reset(reset), .fetchReq(fetchReq), .dataReq(dataReq),
        .fetchResp(fetchResp), .dataResp(dataResp), .apbReq(apbReq), .apbResp(apbResp)
    );

endmodule

// ==== hw/rvCorePkg.sv ====
`include "rvCore_settings.svh"

package rvCorePkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] regIdx_t;
    typedef logic [`CORE_STRB_WIDTH-1:0] strb_t;

    // ------------------------------------------------------------
    // external APB and internal requester buses
    // ------------------------------------------------------------
    typedef struct packed {
        word_t paddr;
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t pwdata;
        strb_t pstrb;
    } apbReq_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apbResp_t;

    typedef struct packed {
        logic  valid;  // held until done
        logic  write;
        word_t addr;
        word_t wdata;
        strb_t strb;
    } memReq_t;

    typedef struct packed {
        logic  done;  // one cycle
        word_t rdata;
    } memResp_t;

    // ------------------------------------------------------------
    // decode and sequencing
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } aluOp_e;

    typedef struct packed {
        aluOp_e     aluOp;
        logic       useImm;
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        logic       branch;
        logic [1:0] branchCond;  // funct3 bits 2 and 0
        logic [1:0] memSize;     // 0 byte, 1 half, 2 word
        logic       memUnsigned;
        regIdx_t    rd;
        regIdx_t    rs1;
        regIdx_t    rs2;
        word_t      imm;
    } ctrl_t;

    typedef enum logic [1:0] {
        STAGE_FETCH,
        STAGE_EXEC,
        STAGE_MEM,
        STAGE_WB
    } stage_e;

endpackage

// ==== hw/rvCore_settings.svh ====
`ifndef RVCORE_SETTINGS_SVH
`define RVCORE_SETTINGS_SVH

// ------------------------------------------------------------
// core widths and reset values
// ------------------------------------------------------------
`define CORE_XLEN 32
`define CORE_RESET_PC 32'h0000_0000

// general register file depth
`define CORE_REG_COUNT 32

// byte lanes on the data path
`define CORE_STRB_WIDTH 4

`endif

// ==== rvCore.f ====
+incdir+hw
hw/rvCorePkg.sv
hw/coreSequencer.sv
hw/fetchUnit.sv
hw/decoder.sv
hw/regFile.sv
hw/execUnit.sv
hw/loadStoreUnit.sv
hw/busArbiter.sv
hw/rvCore.sv
test/rvCore_sva.sv
test/rvCoreTb.sv

// ==== test/rvCoreTb.sv ====
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module rvCoreTb;

    localparam int RESET_CYCLES     = 8;
    localparam int PROGRAM_INSTRS   = 48;          // up to the third halt fetch
    localparam int CYCLES_PER_INSTR = 2 * 6 + 2;   // idle, setup, 4 access per transfer
    localparam int CYCLE_LIMIT      = PROGRAM_INSTRS * CYCLES_PER_INSTR + RESET_CYCLES;
    localparam logic [6:0] OPC_IMM  = 7'h13;
    localparam logic [6:0] OPC_LOAD = 7'h03;

    logic clk;
    logic reset;
    rvCorePkg::apbReq_t apbReq;
    rvCorePkg::apbResp_t apbResp = '0;

    logic [31:0] mem [256];
    logic [31:0] lfsr = 32'hd0c3;
    logic [1:0] waitDraw;
    int waitLeft;
    int progPtr;
    rvCorePkg::word_t haltPc;
    int haltFetches;

    rvCorePkg::word_t expAddr [32];
    rvCorePkg::word_t expData [32];
    rvCorePkg::strb_t expStrb [32];
    int expTest [32];
    int storeCount, storeIdx, unexpectedStores, failedTests;
    int testErrors [4];
    string testName [4] = '{"alu", "load/store", "branch", "x0 write"};

    rvCore dut (.clk(clk), .reset(reset), .apbReq(apbReq), .apbResp(apbResp));

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        lfsrNext = s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    // ------------------------------------------------------------
    // instruction encoders
    // ------------------------------------------------------------
    function automatic logic [31:0] encI(input logic [6:0] op, input int rd,
                                         input logic [2:0] f3, input int rs1, input int imm);
        encI = {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
        encR = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encS(input logic [2:0] f3, input int rs2, input int rs1,
                                         input int imm);
        encS = {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int imm);
        encB = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[progPtr] = word;
        progPtr++;
    endtask

    task automatic loadMemory();
        int aluRegs [9] = '{2, 5, 6, 7, 8, 10, 11, 13, 14};
        for (int i = 0; i < 256; i++) mem[i] = ((i * 4) * 32'h9E37_79B9) ^ 32'h5555_0000;
        mem['h200 >> 2] = 32'h8A7F_C3E5;  // load source word
        progPtr = `CORE_RESET_PC >> 2;
        emit(encI(OPC_IMM, 1, 3'b000, 0, 'h300));   // result base
        emit({20'h12345, 5'd2, 7'b0110111});        // lui x2
        emit(encI(OPC_IMM, 3, 3'b000, 0, 100));
        emit(encI(OPC_IMM, 4, 3'b000, 0, -7));
        emit(encR(7'h00, 4, 3, 3'b000, 5));         // add
        emit(encR(7'h20, 3, 4, 3'b000, 6));         // sub
        emit(encI(OPC_IMM, 9, 3'b110, 2, 'h7FF));   // ori
        emit(encR(7'h00, 4, 9, 3'b111, 7));         // and
        emit(encR(7'h00, 4, 3, 3'b110, 8));         // or
        emit(encR(7'h00, 4, 9, 3'b100, 10));        // xor
        emit(encI(OPC_IMM, 11, 3'b100, 3, 'hF0));   // xori
        emit(encR(7'h00, 3, 4, 3'b010, 13));        // slt
        emit(encI(OPC_IMM, 14, 3'b010, 3, -6));     // slti
        for (int i = 0; i < 9; i++) emit(encS(3'b010, aluRegs[i], 1, 4 * i));
        emit(encI(OPC_IMM, 20, 3'b000, 0, 'h200));
        emit(encI(OPC_LOAD, 15, 3'b000, 20, 1));    // lb
        emit(encI(OPC_LOAD, 16, 3'b100, 20, 3));    // lbu
        emit(encI(OPC_LOAD, 17, 3'b001, 20, 2));    // lh
        emit(encI(OPC_LOAD, 18, 3'b101, 20, 0));    // lhu
        emit(encI(OPC_LOAD, 19, 3'b010, 20, 0));    // lw
        for (int i = 0; i < 4; i++) emit(encS(3'b010, 15 + i, 1, 'h40 + 4 * i));
        emit(encS(3'b000, 19, 1, 'h51));            // sb
        emit(encS(3'b001, 19, 1, 'h56));            // sh
        emit(encB(3'b000, 3, 3, 8));                // beq taken
        emit(encS(3'b010, 3, 1, 'h7C));             // marker
        emit(encB(3'b001, 3, 3, 8));                // bne not taken
        emit(encS(3'b010, 3, 1, 'h60));
        emit(encB(3'b100, 4, 3, 8));                // blt taken
        emit(encS(3'b010, 3, 1, 'h7C));             // marker
        emit(encB(3'b101, 4, 3, 8));                // bge not taken
        emit(encS(3'b010, 4, 1, 'h64));
        emit(encI(OPC_IMM, 0, 3'b000, 0, 123));     // write to x0
        emit(encS(3'b010, 0, 1, 'h68));
        haltPc = progPtr << 2;
        emit(encB(3'b000, 0, 0, 0));                // branch to self
    endtask

    task automatic addExpected(input rvCorePkg::word_t addr, input rvCorePkg::word_t data,
                               input rvCorePkg::strb_t strb, input int test);
        expAddr[storeCount] = addr;
        expData[storeCount] = data;
        expStrb[storeCount] = strb;
        expTest[storeCount] = test;
        storeCount++;
    endtask

    task automatic buildExpected();
        logic [31:0] aluVals [9] = '{32'h1234_5000, 32'h0000_005D, 32'hFFFF_FF95,
                                    32'h1234_57F9, 32'hFFFF_FFFD, 32'hEDCB_A806,
                                    32'h0000_0094, 32'h0000_0001, 32'h0000_0000};
        for (int i = 0; i < 9; i++) addExpected('h300 + 4 * i, aluVals[i], 4'hF, 0);
        addExpected('h340, 32'hFFFF_FFC3, 4'hF, 1);
        addExpected('h344, 32'h0000_008A, 4'hF, 1);
        addExpected('h348, 32'hFFFF_8A7F, 4'hF, 1);
        addExpected('h34C, 32'h0000_C3E5, 4'hF, 1);
        addExpected('h350, 32'h0000_E500, 4'b0010, 1);
        addExpected('h354, 32'hC3E5_0000, 4'b1100, 1);
        addExpected('h360, 32'h0000_0064, 4'hF, 2);
        addExpected('h364, 32'hFFFF_FFF9, 4'hF, 2);
        addExpected('h368, 32'h0000_0000, 4'hF, 3);
    endtask

    task automatic checkStore();
        rvCorePkg::word_t mask;
        int t;
        assert (storeIdx < storeCount) else begin
            unexpectedStores++;
            $display("unexpected store to %h after the last expected one", apbReq.paddr);
        end
        if (storeIdx >= storeCount) return;
        t = expTest[storeIdx];
        for (int b = 0; b < 4; b++) mask[8*b +: 8] = {8{expStrb[storeIdx][b]}};
        assert (apbReq.paddr == expAddr[storeIdx]) else begin
            testErrors[t]++;
            $display("FAILED %0t paddr: got %h, expected %h", $time, apbReq.paddr,
                     expAddr[storeIdx]);
        end
        assert (apbReq.pstrb == expStrb[storeIdx]) else begin
            testErrors[t]++;
            $display("FAILED %0t pstrb: got %b, expected %b", $time, apbReq.pstrb,
                     expStrb[storeIdx]);
        end
        assert ((apbReq.pwdata & mask) == (expData[storeIdx] & mask)) else begin
            testErrors[t]++;
            $display("FAILED %0t pwdata: got %h, expected %h", $time, apbReq.pwdata & mask,
                     expData[storeIdx] & mask);
        end
        storeIdx++;
        if (storeIdx == storeCount || expTest[storeIdx] != t)
            $display("test %0d %s: %s", t, testName[t], testErrors[t] == 0 ? "passed" : "failed");
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // APB memory with 0 to 3 wait states
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            apbResp  <= '0;
            waitLeft <= 0;
        end else if (apbReq.psel && !apbReq.penable) begin
            waitDraw[0] = lfsr[0];
            lfsr = lfsrNext(lfsr);
            waitDraw[1] = lfsr[0];
            lfsr = lfsrNext(lfsr);
            if (waitDraw == 2'd0) begin
                apbResp.pready <= 1'b1;
                apbResp.prdata <= mem[apbReq.paddr[9:2]];
            end else begin
                waitLeft <= waitDraw;
            end
        end else if (apbReq.psel && apbReq.penable) begin
            if (apbResp.pready) begin
                apbResp.pready <= 1'b0;
                for (int b = 0; b < 4; b++)
                    if (apbReq.pwrite && apbReq.pstrb[b])
                        mem[apbReq.paddr[9:2]][8*b +: 8] <= apbReq.pwdata[8*b +: 8];
            end else if (waitLeft == 1) begin
                apbResp.pready <= 1'b1;
                apbResp.prdata <= mem[apbReq.paddr[9:2]];
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && apbReq.psel && apbReq.penable && apbResp.pready) begin
            if (apbReq.pwrite) checkStore();
            else if (apbReq.paddr == haltPc) haltFetches++;
        end
    end

    initial begin
        repeat (CYCLE_LIMIT) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d stores seen", CYCLE_LIMIT,
                 storeIdx, storeCount);
        $display("Errors found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        loadMemory();
        buildExpected();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (storeIdx < storeCount || haltFetches < 3) @(negedge clk);
        failedTests = 0;
        foreach (testErrors[t]) if (testErrors[t] != 0) failedTests++;
        $display("tests passed: %0d, failed: %0d, unexpected stores: %0d, assertion failures: %0d",
                 4 - failedTests, failedTests, unexpectedStores, dut.uSva.failCount);
        if (failedTests == 0 && unexpectedStores == 0 && dut.uSva.failCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== test/rvCore_sva.sv ====
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module rvCoreSva (
    input logic                clk,
    input logic                reset,
    input rvCorePkg::apbReq_t  apbReq,
    input rvCorePkg::apbResp_t apbResp,
    input rvCorePkg::memReq_t  fetchReq,
    input rvCorePkg::memReq_t  dataReq,
    input rvCorePkg::memResp_t fetchResp
);

    int failCount = 0;
    logic firstSeen, havePrev;
    rvCorePkg::word_t prevPc, prevInstr;  // last completed fetch

    // B-type offset as the ISA defines it
    function automatic rvCorePkg::word_t branchOffset(input rvCorePkg::word_t i);
        branchOffset = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            firstSeen <= 1'b0;
            havePrev  <= 1'b0;
        end else begin
            if (apbReq.psel) firstSeen <= 1'b1;
            if (fetchResp.done) begin
                prevPc    <= apbReq.paddr;
                prevInstr <= apbResp.prdata;
                havePrev  <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // reset and first transfer
    // ------------------------------------------------------------
    resetIdle: assert property (@(posedge clk) reset |=> !apbReq.psel && !apbReq.penable)
        else begin
            failCount++;
            $error("APB select or enable active right after reset");
        end

    firstFetch: assert property (@(posedge clk) disable iff (reset)
        apbReq.psel && !firstSeen |-> apbReq.paddr == `CORE_RESET_PC && !apbReq.pwrite)
        else begin
            failCount++;
            $error("FAILED %0t paddr: got %h, expected %h", $time, $sampled(apbReq.paddr),
                   `CORE_RESET_PC);
        end

    // ------------------------------------------------------------
    // APB phases under wait states
    // ------------------------------------------------------------
    enableNeedsSelect: assert property (@(posedge clk) disable iff (reset)
        apbReq.penable |-> apbReq.psel)
        else begin
            failCount++;
            $error("penable high without psel");
        end

    setupThenAccess: assert property (@(posedge clk) disable iff (reset)
        apbReq.psel && !apbReq.penable |=> apbReq.psel && apbReq.penable)
        else begin
            failCount++;
            $error("setup cycle not followed by an access cycle");
        end

    holdWhileWaiting: assert property (@(posedge clk) disable iff (reset)
        apbReq.psel && apbReq.penable && !apbResp.pready |=>
            apbReq.psel && apbReq.penable && $stable(apbReq.paddr) &&
            $stable(apbReq.pwrite) && $stable(apbReq.pwdata) && $stable(apbReq.pstrb))
        else begin
            failCount++;
            $error("APB request changed while pready was low");
        end

    dropAfterReady: assert property (@(posedge clk) disable iff (reset)
        apbReq.psel && apbReq.penable && apbResp.pready |=> !apbReq.psel)
        else begin
            failCount++;
            $error("psel did not drop after a completed transfer");
        end

    singleRequester: assert property (@(posedge clk) disable iff (reset)
        !(fetchReq.valid && dataReq.valid))
        else begin
            failCount++;
            $error("fetch and data requests pending together");
        end

    // next fetch is pc + 4 or the branch target of the previous instruction
    fetchOrder: assert property (@(posedge clk) disable iff (reset)
        fetchResp.done && havePrev |-> apbReq.paddr == prevPc + 4 ||
            (prevInstr[6:0] == 7'b1100011 && apbReq.paddr == prevPc + branchOffset(prevInstr)))
        else begin
            failCount++;
            $error("FAILED %0t fetch paddr: got %h, expected %h or %h", $time,
                   $sampled(apbReq.paddr), $sampled(prevPc) + 4,
                   $sampled(prevPc) + branchOffset($sampled(prevInstr)));
        end

endmodule

bind rvCore rvCoreSva uSva (
    .clk(clk), .reset(reset), .apbReq(apbReq), .apbResp(apbResp),
    .fetchReq(fetchReq), .dataReq(dataReq), .fetchResp(fetchResp)
);
